// File: verilog/fb_settings.svh
/*
 * Feedback sampler sizes
 * Channel count, snapshot length and bus address widths
 */

`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// Feedback channels on the board
`define FB_NUM_CHAN 4
// Word kinds per channel (ADC, pos, period, qtr1, qtr5, running)
`define FB_NUM_OFFS 6

// Timestamp + 3 global words + 4 x 6 channel words
`define NUM_RT_READ_QUADS 28

`define FB_ADDR_W 5     // Snapshot and hub address for 32 quadlets
`define WB_ADR_W  7     // Wishbone word address

`endif

// File: verilog/fb_pkg.sv
/*
 * Feedback sampler types
 * Sampler FSM state and the broadcast header word
 */

package fb_pkg;

   // Sampler FSM states
   typedef enum logic [1:0] {
      SD_IDLE      = 2'd0,
      SD_SAMPLING  = 2'd1,   // Walking the channels
      SD_WRITE_HUB = 2'd2    // Copying header + snapshot to hub
   } sd_state_t;

   // Broadcast header as host fields or as one quadlet
   typedef union packed {
      struct packed {
         logic [15:0] bc_seq;      // Sequence number in the upper half
         logic [15:0] board_mask;  // Board mask in the lower half
      } f;
      logic [31:0] raw;            // Hub word 0 as written
   } hub_hdr_u;

endpackage

// File: verilog/fb_chan_if.sv
/*
 * Channel feedback bus between sampler and register bank
 */

`timescale 1ns/1ps

interface fb_chan_if;

   logic [3:0]  chan;         // 1 to 4 select a channel
   logic [31:0] adc;          // Motor current and pot
   logic [31:0] enc_pos;      // Quadrature position
   logic [31:0] enc_period;   // Velocity period
   logic [31:0] enc_qtr1;     // Quarter period last cycle
   logic [31:0] enc_qtr5;     // Quarter period 5 cycles ago
   logic [31:0] enc_run;      // Running counter

   modport sampler (output chan,
                    input  adc, enc_pos, enc_period, enc_qtr1, enc_qtr5, enc_run);

   modport source  (input  chan,
                    output adc, enc_pos, enc_period, enc_qtr1, enc_qtr5, enc_run);

endinterface

// File: verilog/chan_feedback_regs.sv
/*
 * Per-channel feedback register bank
 * Host-loaded words standing in for the ADC and encoder front ends
 */

`timescale 1ns/1ps
`include "fb_settings.svh"

module chan_feedback_regs (
   input  logic        clk,
   input  logic        rst,
   input  logic        we,       // Host write strobe
   input  logic [4:0]  waddr,    // kind*4 + channel
   input  logic [31:0] wdata,
   fb_chan_if.source   fb
);

   logic [31:0] regs [`FB_NUM_OFFS][`FB_NUM_CHAN];
   logic [2:0]  w_kind;
   logic [1:0]  w_chan;
   logic [1:0]  r_chan;
   logic        r_valid;

   assign w_kind = waddr[4:2];
   assign w_chan = waddr[1:0];

   // Write side
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k < `FB_NUM_OFFS; k++) begin
            for (int c = 0; c < `FB_NUM_CHAN; c++) begin
               regs[k][c] <= '0;
            end
         end
      end else if (we && (w_kind < 3'(`FB_NUM_OFFS))) begin
         regs[w_kind][w_chan] <= wdata;
      end
   end

   // Read side with 1-based chan on the bus
   assign r_valid = (fb.chan >= 4'd1) && (fb.chan <= 4'(`FB_NUM_CHAN));
   assign r_chan  = 2'(fb.chan - 4'd1);

   assign fb.adc        = r_valid ? regs[0][r_chan] : '0;
   assign fb.enc_pos    = r_valid ? regs[1][r_chan] : '0;
   assign fb.enc_period = r_valid ? regs[2][r_chan] : '0;
   assign fb.enc_qtr1   = r_valid ? regs[3][r_chan] : '0;
   assign fb.enc_qtr5   = r_valid ? regs[4][r_chan] : '0;
   assign fb.enc_run    = r_valid ? regs[5][r_chan] : '0;   // Zero outside 1..4

   // Bus decode must keep writes inside the 24-word bank
   a_waddr_range: assert property (@(posedge clk) disable iff (rst)
      we |-> (waddr < 5'(`FB_NUM_CHAN * `FB_NUM_OFFS)))
      else $error("channel register write to index %0d", waddr);

endmodule

// File: verilog/sample_data.sv
/*
 * Real-time feedback sampler
 * Freezes timestamp, global and channel words into a 32-quadlet snapshot
 * and optionally streams header + snapshot into the hub memory
 */

`timescale 1ns/1ps
`include "fb_settings.svh"

module sample_data (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  do_sample,    // Start pulse
   input  logic                  write_hub,    // Copy to hub after sampling
   output logic                  busy,
   input  logic [31:0]           reg_status,
   input  logic [31:0]           reg_digio,
   input  logic [31:0]           reg_temp,
   input  fb_pkg::hub_hdr_u      hub_hdr,
   fb_chan_if.sampler            fb,
   input  logic [`FB_ADDR_W-1:0] blk_addr,     // Host snapshot read
   output logic [31:0]           blk_data,
   output logic                  hub_wen,
   output logic [`FB_ADDR_W-1:0] hub_waddr,
   output logic [31:0]           hub_wdata
);

   logic [31:0]           snap [2**`FB_ADDR_W];   // Snapshot quadlets
   fb_pkg::sd_state_t     state;
   logic [3:0]            chan;
   logic [31:0]           timestamp;
   logic                  hub_pending;            // Hub copy requested
   logic [`FB_ADDR_W-1:0] ch_off;

   assign fb.chan   = chan;
   assign busy      = (state != fb_pkg::SD_IDLE);
   assign blk_data  = snap[blk_addr];
   assign ch_off    = {1'b0, chan};
   // Header at hub word 0 and the snapshot one word up
   assign hub_wdata = (hub_waddr == '0) ? hub_hdr.raw : snap[hub_waddr - 1'b1];

   // ------------------------------------------------------------------
   // Timestamp counts cycles since the previous sample
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         timestamp <= '0;
      end else if ((state == fb_pkg::SD_SAMPLING) && (chan == 4'd1)) begin
         timestamp <= '0;                    // Restart on first channel step
      end else begin
         timestamp <= timestamp + 32'd1;
      end
   end

   // ------------------------------------------------------------------
   // Sampler FSM
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= fb_pkg::SD_IDLE;
         chan        <= '0;
         hub_pending <= 1'b0;
         hub_wen     <= 1'b0;
         hub_waddr   <= '0;
         for (int i = 0; i < 2**`FB_ADDR_W; i++) begin
            snap[i] <= '0;
         end
      end else begin
         case (state)
            fb_pkg::SD_IDLE: begin
               if (do_sample) begin              // Starts ignored while busy
                  chan        <= 4'd1;
                  hub_pending <= write_hub;
                  state       <= fb_pkg::SD_SAMPLING;
               end
            end

            fb_pkg::SD_SAMPLING: begin
               chan <= chan + 4'd1;
               if (chan == 4'd1) begin
                  snap[0] <= timestamp;          // Old count before clear
                  snap[1] <= reg_status;
                  snap[2] <= reg_digio;
                  snap[3] <= reg_temp;
               end
               if (chan == 4'(`FB_NUM_CHAN + 1)) begin
                  // Past the last channel
                  if (hub_pending) begin
                     state       <= fb_pkg::SD_WRITE_HUB;
                     hub_waddr   <= '0;
                     hub_wen     <= 1'b1;
                     hub_pending <= 1'b0;
                  end else begin
                     state <= fb_pkg::SD_IDLE;
                  end
               end else begin
                  snap[5'd3  + ch_off] <= fb.adc;
                  snap[5'd7  + ch_off] <= fb.enc_pos;
                  snap[5'd11 + ch_off] <= fb.enc_period;
                  snap[5'd15 + ch_off] <= fb.enc_qtr1;
                  snap[5'd19 + ch_off] <= fb.enc_qtr5;
                  snap[5'd23 + ch_off] <= fb.enc_run;
               end
            end

            fb_pkg::SD_WRITE_HUB: begin
               hub_waddr <= hub_waddr + 1'b1;
               if (hub_waddr == `NUM_RT_READ_QUADS) begin
                  state   <= fb_pkg::SD_IDLE;    // Last quadlet written
                  hub_wen <= 1'b0;
               end
            end

            default: state <= fb_pkg::SD_IDLE;
         endcase
      end
   end

   a_hub_wen_state: assert property (@(posedge clk) disable iff (rst)
      hub_wen |-> (state == fb_pkg::SD_WRITE_HUB))
      else $error("hub write outside hub state");

   a_chan_range: assert property (@(posedge clk) disable iff (rst)
      (state == fb_pkg::SD_SAMPLING) |-> (chan inside {[4'd1 : 4'd5]}))
      else $error("channel index %0d while sampling", chan);

endmodule

// File: verilog/hub_mem.sv
/*
 * Hub receive buffer
 * One write port from the sampler, combinational host read
 */

`timescale 1ns/1ps
`include "fb_settings.svh"

module hub_mem (
   input  logic                  clk,
   input  logic                  wen,
   input  logic [`FB_ADDR_W-1:0] waddr,
   input  logic [31:0]           wdata,
   input  logic [`FB_ADDR_W-1:0] raddr,
   output logic [31:0]           rdata
);

   logic [31:0] mem [2**`FB_ADDR_W];

   // Buffer starts cleared at power-up
   initial begin
      for (int i = 0; i < 2**`FB_ADDR_W; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
   end

   assign rdata = mem[raddr];   // Async read for the bus mux

endmodule

// File: verilog/wb_fb_slave.sv
/*
 * Wishbone classic slave for the feedback block
 * Control, global and header registers plus the read-back mux
 */

`timescale 1ns/1ps
`include "fb_settings.svh"

module wb_fb_slave (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [`WB_ADR_W-1:0]  wb_adr,
   input  logic [31:0]           wb_dat_i,
   output logic [31:0]           wb_dat_o,
   output logic                  wb_ack,
   output logic                  do_sample,
   output logic                  write_hub,
   input  logic                  busy,
   output logic [31:0]           reg_status,
   output logic [31:0]           reg_digio,
   output logic [31:0]           reg_temp,
   output fb_pkg::hub_hdr_u      hub_hdr,
   output logic                  ch_we,
   output logic [4:0]            ch_waddr,
   output logic [31:0]           ch_wdata,
   output logic [`FB_ADDR_W-1:0] blk_addr,
   input  logic [31:0]           blk_data,
   output logic [`FB_ADDR_W-1:0] hub_raddr,
   input  logic [31:0]           hub_rdata
);

   logic        wb_req;
   logic        wr_en;     // Write takes effect on the ack cycle
   logic        ch_sel;
   logic [31:0] rd_mux;

   assign wb_req = wb_cyc && wb_stb;
   assign wr_en  = wb_ack && wb_we;
   assign ch_sel = (wb_adr[6:5] == 2'b01) &&
                   (wb_adr[4:0] < 5'(`FB_NUM_CHAN * `FB_NUM_OFFS));

   // One-cycle control pulses
   assign do_sample = wr_en && (wb_adr == '0) && wb_dat_i[0];
   assign write_hub = wr_en && (wb_adr == '0) && wb_dat_i[1];

   assign ch_we     = wr_en && ch_sel;       // 0x20..0x37
   assign ch_waddr  = wb_adr[4:0];
   assign ch_wdata  = wb_dat_i;
   assign blk_addr  = wb_adr[`FB_ADDR_W-1:0];
   assign hub_raddr = wb_adr[`FB_ADDR_W-1:0];

   // ------------------------------------------------------------------
   // Single-cycle ack and registered read data
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= wb_req && !wb_ack;        // Drops even if stb stays high
      end
   end

   always_ff @(posedge clk) begin
      if (wb_req && !wb_ack) begin
         wb_dat_o <= rd_mux;
      end
   end

   // Global and header registers
   always_ff @(posedge clk) begin
      if (rst) begin
         reg_status  <= '0;
         reg_digio   <= '0;
         reg_temp    <= '0;
         hub_hdr.raw <= '0;
      end else if (wr_en) begin
         case (wb_adr)
            7'h01: reg_status <= wb_dat_i;
            7'h02: reg_digio  <= wb_dat_i;
            7'h03: reg_temp   <= wb_dat_i;
            7'h04: begin
               hub_hdr.f.bc_seq     <= wb_dat_i[31:16];
               hub_hdr.f.board_mask <= wb_dat_i[15:0];
            end
            default: ;
         endcase
      end
   end

   always_comb begin
      rd_mux = '0;
      case (wb_adr[6:5])
         2'b00: begin
            case (wb_adr[4:0])
               5'h00: rd_mux = {31'd0, busy};
               5'h01: rd_mux = reg_status;
               5'h02: rd_mux = reg_digio;
               5'h03: rd_mux = reg_temp;
               5'h04: rd_mux = hub_hdr.raw;
               default: rd_mux = '0;
            endcase
         end
         2'b10:   rd_mux = blk_data;         // Snapshot quadlets
         2'b11:   rd_mux = hub_rdata;        // Hub words
         default: rd_mux = '0;               // Channel bank reads zero
      endcase
   end

   // Master must hold the strobe until ack
   a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack outside a bus cycle");

endmodule

// File: verilog/fb_top.sv
/*
 * Feedback sampling block top level
 * Wishbone slave, channel bank, sampler and hub memory
 */

`timescale 1ns/1ps
`include "fb_settings.svh"

module fb_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [`WB_ADR_W-1:0] wb_adr,
   input  logic [31:0]          wb_dat_i,
   output logic [31:0]          wb_dat_o,
   output logic                 wb_ack
);

   logic                  do_sample, write_hub, busy;
   logic [31:0]           reg_status, reg_digio, reg_temp;
   fb_pkg::hub_hdr_u      hub_hdr;
   logic                  ch_we;
   logic [4:0]            ch_waddr;
   logic [31:0]           ch_wdata;
   logic [`FB_ADDR_W-1:0] blk_addr, hub_raddr, hub_waddr;
   logic [31:0]           blk_data, hub_rdata, hub_wdata;
   logic                  hub_wen;

   fb_chan_if fb_bus ();   // Sampler to channel bank

   wb_fb_slave u_wb (
      .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
      .do_sample, .write_hub, .busy, .reg_status, .reg_digio, .reg_temp, .hub_hdr,
      .ch_we, .ch_waddr, .ch_wdata, .blk_addr, .blk_data, .hub_raddr, .hub_rdata);

   chan_feedback_regs u_chan (
      .clk, .rst, .we(ch_we), .waddr(ch_waddr), .wdata(ch_wdata), .fb(fb_bus.source));

   sample_data u_sample (
      .clk, .rst, .do_sample, .write_hub, .busy, .reg_status, .reg_digio, .reg_temp,
      .hub_hdr, .fb(fb_bus.sampler), .blk_addr, .blk_data, .hub_wen, .hub_waddr,
      .hub_wdata);

   hub_mem u_hub (
      .clk, .wen(hub_wen), .waddr(hub_waddr), .wdata(hub_wdata),
      .raddr(hub_raddr), .rdata(hub_rdata));

endmodule

// File: verif/fb_top_tb.sv
/*
 * Testbench for the feedback sampling block
 * Wishbone host model, snapshot and hub checks, bus protocol assertions
 */

`timescale 1ns/1ps
`include "fb_settings.svh"

module fb_top_tb;

   localparam int ACK_LIMIT  = 20;    // Cycles to wait for wb_ack
   localparam int POLL_LIMIT = 100;   // Busy polls before giving up

   logic                 clk;
   logic                 rst;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   logic [`WB_ADR_W-1:0] wb_adr;
   logic [31:0]          wb_dat_i;
   logic [31:0]          wb_dat_o;
   logic                 wb_ack;

   integer      seed = 34410;
   int          errors = 0;
   int          proto_errors = 0;
   int          timeouts = 0;
   int unsigned cycles = 0;                                   // Free-running cycle count
   logic [31:0] exp_ch [`FB_NUM_OFFS][`FB_NUM_CHAN];         // Host copy of channel bank
   logic [31:0] exp_status, exp_digio, exp_temp;
   logic [31:0] rd, ts, snap0;
   logic [15:0] hdr_seq, hdr_mask;
   int unsigned t_first, t_second;

   fb_top dut_i (.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycles <= cycles + 1;

   // ------------------------------------------------------------------
   // Wishbone protocol
   // ------------------------------------------------------------------
   ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
      else begin
         proto_errors++;
         $display("Bus protocol: wb_ack stayed high for more than one cycle at %0t", $time);
      end

   ack_in_request: assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> (wb_cyc && wb_stb))
      else begin
         proto_errors++;
         $display("Bus protocol: wb_ack seen without cyc and stb at %0t", $time);
      end

   // Single access entered and left 1 ns after a rising edge
   task automatic bus_access(input logic we, input logic [6:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      n = 0;
      rdata    = '0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_i = wdata;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (!wb_ack && n < ACK_LIMIT);
      if (!wb_ack) begin
         timeouts++;
         $display("Timeout: no ack for access to address %h", adr);
      end else begin
         rdata = wb_dat_o;            // Valid with ack
         @(posedge clk);              // Strobe held over the ack edge
         #1;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input logic [6:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(1'b1, adr, data, unused);
   endtask

   task automatic bus_read(input logic [6:0] adr, output logic [31:0] data);
      bus_access(1'b0, adr, '0, data);
   endtask

   // Poll control until busy drops
   task automatic wait_idle();
      logic [31:0] ctrl;
      int          n;
      n = 0;
      do begin
         bus_read(7'h00, ctrl);
         n++;
      end while (ctrl[0] && n < POLL_LIMIT);
      if (ctrl[0]) begin
         timeouts++;
         $display("Timeout: sampler still busy after %0d polls", n);
      end
   endtask

   task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
         else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
         end
   endtask

   // Globals at quadlets 1..3 and channel words at 4 + kind*4 + channel
   function automatic logic [31:0] snap_expect(input int q);
      int idx;
      idx = q - 4;
      case (q)
         1: return exp_status;
         2: return exp_digio;
         3: return exp_temp;
         default: return exp_ch[idx / 4][idx % 4];
      endcase
   endfunction

   task automatic check_snapshot(input string name);
      logic [31:0] data;
      for (int q = 1; q < `NUM_RT_READ_QUADS; q++) begin
         bus_read(7'(8'h40 + q), data);
         compare_word($sformatf("%s quad %0d", name, q), snap_expect(q), data);
      end
   endtask

   initial begin
      rst      = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_i = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      // Everything reads zero out of reset
      bus_read(7'h00, rd);
      compare_word("reset busy", 32'd0, rd);
      for (int q = 0; q < 32; q++) begin
         bus_read(7'(8'h40 + q), rd);
         compare_word($sformatf("reset snapshot %0d", q), 32'd0, rd);
         bus_read(7'(8'h60 + q), rd);
         compare_word($sformatf("reset hub %0d", q), 32'd0, rd);
      end

      // Channel bank and global words come out of reset cleared
      exp_status = '0;
      exp_digio  = '0;
      exp_temp   = '0;
      for (int k = 0; k < `FB_NUM_OFFS; k++) begin
         for (int c = 0; c < `FB_NUM_CHAN; c++) begin
            exp_ch[k][c] = '0;
         end
      end
      bus_write(7'h00, 32'h1);
      wait_idle();
      check_snapshot("reset channel bank");

      // Random feedback words
      exp_status = $random(seed);
      exp_digio  = $random(seed);
      exp_temp   = $random(seed);
      bus_write(7'h01, exp_status);
      bus_write(7'h02, exp_digio);
      bus_write(7'h03, exp_temp);
      for (int k = 0; k < `FB_NUM_OFFS; k++) begin
         for (int c = 0; c < `FB_NUM_CHAN; c++) begin
            exp_ch[k][c] = $random(seed);
            bus_write(7'(8'h20 + k * 4 + c), exp_ch[k][c]);
         end
      end

      bus_write(7'h00, 32'h1);             // Sample without hub copy
      t_first = cycles;
      wait_idle();
      check_snapshot("first sample");

      // Timestamp covers the gap between starts
      bus_write(7'h00, 32'h1);
      t_second = cycles;
      wait_idle();
      check_snapshot("second sample");
      bus_read(7'h40, ts);
      assert ((ts > 0) && (ts <= t_second - t_first + 1))
         else begin
            errors++;
            $display("ERROR timestamp: expected 1..%0d, actual %0d", t_second - t_first + 1, ts);
         end

      // Header plus snapshot into the hub
      hdr_seq  = $random(seed);
      hdr_mask = $random(seed);
      bus_write(7'h04, {hdr_seq, hdr_mask});
      bus_write(7'h00, 32'h3);
      wait_idle();
      bus_read(7'h40, snap0);
      bus_read(7'h60, rd);
      compare_word("hub header", {hdr_seq, hdr_mask}, rd);
      bus_read(7'h61, rd);
      compare_word("hub word 1", snap0, rd);
      for (int q = 1; q < `NUM_RT_READ_QUADS; q++) begin
         bus_read(7'(8'h61 + q), rd);
         compare_word($sformatf("hub word %0d", q + 1), snap_expect(q), rd);
      end

      // Channel 0 is captured on the first step of this long busy window
      bus_write(7'h00, 32'h3);
      for (int k = 0; k < `FB_NUM_OFFS; k++) begin
         bus_write(7'(8'h20 + k * 4), ~exp_ch[k][0]);   // Expected copy keeps the old words
      end
      bus_read(7'h00, rd);
      compare_word("busy before ignored start", 32'd1, rd);
      bus_write(7'h00, 32'h1);             // Dropped by the sampler
      wait_idle();
      check_snapshot("ignored start");

      $display("Check errors: %0d, bus protocol errors: %0d, timeouts: %0d",
               errors, proto_errors, timeouts);
      if ((errors + proto_errors + timeouts) == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: sample_fb.f
+incdir+verilog
verilog/fb_pkg.sv
verilog/fb_chan_if.sv
verilog/chan_feedback_regs.sv
verilog/sample_data.sv
verilog/hub_mem.sv
verilog/wb_fb_slave.sv
verilog/fb_top.sv
verif/fb_top_tb.sv

// File: Bender.yml
package:
  name: sample_fb

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fb_pkg.sv
      - verilog/fb_chan_if.sv
      - verilog/chan_feedback_regs.sv
      - verilog/sample_data.sv
      - verilog/hub_mem.sv
      - verilog/wb_fb_slave.sv
      - verilog/fb_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/fb_top_tb.sv
